// ==== hdl/muldiv_config.svh ====
`ifndef MULDIV_CONFIG_SVH
`define MULDIV_CONFIG_SVH

// Operand and result width
`define MULDIV_XLEN 32

// One quotient bit per iteration
`define MULDIV_DIV_STEPS `MULDIV_XLEN

// Multiplier splits each operand into two halves of this width
`define MULDIV_HALF 16

`endif

// ==== hdl/muldiv_pkg.sv ====
`include "muldiv_config.svh"

package muldiv_pkg;

    // Supported operations
    typedef enum logic [1:0] {
        OP_MUL = 2'd0,
        OP_DIV = 2'd1,
        OP_REM = 2'd2
    } muldiv_op_t;

    // One request, sampled while start is high
    typedef struct packed {
        muldiv_op_t               op;
        logic [`MULDIV_XLEN-1:0]  a;
        logic [`MULDIV_XLEN-1:0]  b;
    } muldiv_req_t;

endpackage

// ==== hdl/operand_pkg.sv ====
package operand_pkg;

    // Operand values with a known short-cut result
    typedef enum logic [1:0] {
        CLS_OTHER     = 2'd0,
        CLS_ZERO      = 2'd1,
        CLS_ONE       = 2'd2,
        CLS_MINUS_ONE = 2'd3
    } operand_class_t;

    // Class of both operands of one request
    typedef struct packed {
        operand_class_t a_class;
        operand_class_t b_class;
    } operand_status_t;

endpackage

// ==== hdl/fast_path.sv ====
`include "muldiv_config.svh"

module fast_path
    import muldiv_pkg::*;
    import operand_pkg::*;
(
    input  muldiv_req_t              req,
    output logic                     fast,
    output logic [`MULDIV_XLEN-1:0]  fast_result
);

    operand_status_t          status;
    logic [`MULDIV_XLEN-1:0]  neg_a;
    logic [`MULDIV_XLEN-1:0]  neg_b;

    function automatic operand_class_t classify(input logic [`MULDIV_XLEN-1:0] v);
        if (v == '0)
            return CLS_ZERO;
        else if (v == `MULDIV_XLEN'd1)
            return CLS_ONE;
        else if (v == '1)
            return CLS_MINUS_ONE;
        else
            return CLS_OTHER;
    endfunction

    assign status.a_class = classify(req.a);
    assign status.b_class = classify(req.b);

    // Two's complement negation, wraps for the most negative value
    assign neg_a = -req.a;
    assign neg_b = -req.b;

    // Rules in priority order, A = 0 first
    always_comb begin
        fast = 1'b1;
        fast_result = '0;
        if (status.a_class == CLS_ZERO) begin
            fast_result = '0;
        end else if (status.b_class == CLS_ZERO) begin
            // Divide by zero gives all ones, remainder keeps A
            case (req.op)
                OP_DIV:  fast_result = '1;
                OP_REM:  fast_result = req.a;
                default: fast_result = '0;
            endcase
        end else if (status.b_class == CLS_ONE) begin
            fast_result = (req.op == OP_REM) ? '0 : req.a;
        end else if (status.b_class == CLS_MINUS_ONE) begin
            fast_result = (req.op == OP_REM) ? '0 : neg_a;
        end else if (status.a_class == CLS_ONE) begin
            // |B| > 1 here, so 1 / B truncates to 0
            case (req.op)
                OP_DIV:  fast_result = '0;
                OP_REM:  fast_result = `MULDIV_XLEN'd1;
                default: fast_result = req.b;
            endcase
        end else if (status.a_class == CLS_MINUS_ONE) begin
            case (req.op)
                OP_DIV:  fast_result = '0;
                OP_REM:  fast_result = '1;
                default: fast_result = neg_b;
            endcase
        end else begin
            // Needs the datapath
            fast = 1'b0;
        end
    end

endmodule

// ==== hdl/mul_pipe.sv ====
`include "muldiv_config.svh"

module mul_pipe (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`MULDIV_XLEN-1:0]  mul_a,
    input  logic [`MULDIV_XLEN-1:0]  mul_b,
    output logic [`MULDIV_XLEN-1:0]  product
);

    localparam int HALF = `MULDIV_HALF;

    logic [HALF-1:0]          cross_lh;
    logic [HALF-1:0]          cross_hl;
    logic [`MULDIV_XLEN-1:0]  lo_lo;
    logic [HALF-1:0]          lo_hi;
    logic [HALF-1:0]          hi_lo;

    // Cross products only reach the upper half of the low word
    assign cross_lh = mul_a[HALF-1:0] * mul_b[`MULDIV_XLEN-1:HALF];
    assign cross_hl = mul_a[`MULDIV_XLEN-1:HALF] * mul_b[HALF-1:0];

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lo_lo <= '0;
            lo_hi <= '0;
            hi_lo <= '0;
            product <= '0;
        end else begin
            // Stage one registers the partial products
            lo_lo <= mul_a[HALF-1:0] * mul_b[HALF-1:0];
            lo_hi <= cross_lh;
            hi_lo <= cross_hl;
            // Stage two adds the cross terms shifted up
            product <= lo_lo + {lo_hi + hi_lo, {HALF{1'b0}}};
        end
    end

endmodule

// ==== hdl/div_serial.sv ====
`include "muldiv_config.svh"

module div_serial (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     div_start,
    input  logic [`MULDIV_XLEN-1:0]  div_a,
    input  logic [`MULDIV_XLEN-1:0]  div_b,
    output logic                     div_ready,
    output logic [`MULDIV_XLEN-1:0]  quotient,
    output logic [`MULDIV_XLEN-1:0]  remainder
);

    localparam int CNT_W = $clog2(`MULDIV_DIV_STEPS + 1);

    logic                     busy;
    logic [CNT_W-1:0]         count;
    logic                     step;
    logic [`MULDIV_XLEN-1:0]  quo;
    logic [`MULDIV_XLEN-1:0]  rem;
    logic [`MULDIV_XLEN-1:0]  divisor;
    logic                     q_neg;
    logic                     r_neg;
    logic [`MULDIV_XLEN:0]    shifted;
    logic [`MULDIV_XLEN:0]    diff;

    // Next dividend bit shifts from quo into the partial remainder
    assign shifted = {rem, quo[`MULDIV_XLEN-1]};
    // Top bit set means the trial subtraction borrowed
    assign diff = shifted - {1'b0, divisor};

    assign step = busy && (count != '0);
    assign div_ready = busy && (count == '0);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            busy <= 1'b0;
            count <= '0;
        end else if (div_start) begin
            busy <= 1'b1;
            count <= CNT_W'(`MULDIV_DIV_STEPS);
        end else if (div_ready) begin
            busy <= 1'b0;
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            // Work on magnitudes, signs fixed at the end
            quo <= div_a[`MULDIV_XLEN-1] ? -div_a : div_a;
            rem <= '0;
            divisor <= div_b[`MULDIV_XLEN-1] ? -div_b : div_b;
            q_neg <= div_a[`MULDIV_XLEN-1] ^ div_b[`MULDIV_XLEN-1];
            r_neg <= div_a[`MULDIV_XLEN-1];
        end else if (step) begin
            if (!diff[`MULDIV_XLEN]) begin
                rem <= diff[`MULDIV_XLEN-1:0];
                quo <= {quo[`MULDIV_XLEN-2:0], 1'b1};
            end else begin
                // Restore, keep the shifted remainder
                rem <= shifted[`MULDIV_XLEN-1:0];
                quo <= {quo[`MULDIV_XLEN-2:0], 1'b0};
            end
        end
    end

    // Truncation toward zero, remainder takes the sign of A
    assign quotient = q_neg ? -quo : quo;
    assign remainder = r_neg ? -rem : rem;

endmodule

// ==== hdl/muldiv_ctrl.sv ====
`include "muldiv_config.svh"

module muldiv_ctrl
    import muldiv_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  muldiv_req_t              req,
    input  logic                     fast,
    input  logic [`MULDIV_XLEN-1:0]  fast_result,
    input  logic [`MULDIV_XLEN-1:0]  product,
    input  logic                     div_ready,
    input  logic [`MULDIV_XLEN-1:0]  quotient,
    input  logic [`MULDIV_XLEN-1:0]  remainder,
    output logic [`MULDIV_XLEN-1:0]  mul_a,
    output logic [`MULDIV_XLEN-1:0]  mul_b,
    output logic                     div_start,
    output logic [`MULDIV_XLEN-1:0]  div_a,
    output logic [`MULDIV_XLEN-1:0]  div_b,
    output logic                     done,
    output logic [`MULDIV_XLEN-1:0]  result
);

    typedef enum logic [2:0] {IDLE, MUL1, MUL2, MUL_OUT, DIV_WAIT, DIV_OUT} state_t;

    state_t                   state;
    state_t                   next_state;
    muldiv_op_t               op_q;
    logic [`MULDIV_XLEN-1:0]  a_q;
    logic [`MULDIV_XLEN-1:0]  b_q;
    logic [`MULDIV_XLEN-1:0]  quo_q;
    logic [`MULDIV_XLEN-1:0]  rem_q;
    logic                     is_div;
    logic                     slow_start;

    // Unknown op codes run as MUL, same as in fast_path
    assign is_div = (req.op == OP_DIV) || (req.op == OP_REM);
    assign slow_start = (state == IDLE) && start && !fast;

    always_comb begin
        next_state = state;
        case (state)
            IDLE:     if (slow_start) next_state = is_div ? DIV_WAIT : MUL1;
            MUL1:     next_state = MUL2;
            MUL2:     next_state = MUL_OUT;
            DIV_WAIT: if (div_ready) next_state = DIV_OUT;
            default:  next_state = IDLE;
        endcase
    end

    // div_start is high in the first DIV_WAIT cycle only
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            state <= IDLE;
            div_start <= 1'b0;
        end else begin
            state <= next_state;
            div_start <= slow_start && is_div;
        end
    end

    // Operands held for the whole slow operation
    always_ff @(posedge clk) begin
        if (slow_start) begin
            op_q <= req.op;
            a_q <= req.a;
            b_q <= req.b;
        end
        if ((state == DIV_WAIT) && div_ready) begin
            quo_q <= quotient;
            rem_q <= remainder;
        end
    end

    assign mul_a = a_q;
    assign mul_b = b_q;
    assign div_a = a_q;
    assign div_b = b_q;

    // Fast result finishes in the start cycle
    assign done = ((state == IDLE) && start && fast) || (state == MUL_OUT) || (state == DIV_OUT);

    always_comb begin
        case (state)
            IDLE:    result = fast_result;
            MUL_OUT: result = product;
            DIV_OUT: result = (op_q == OP_REM) ? rem_q : quo_q;
            default: result = '0;
        endcase
    end

endmodule

// ==== hdl/muldiv_top.sv ====
`include "muldiv_config.svh"

module muldiv_top
    import muldiv_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     start,
    input  muldiv_req_t              req,
    output logic                     done,
    output logic [`MULDIV_XLEN-1:0]  result
);

    logic                     fast;
    logic [`MULDIV_XLEN-1:0]  fast_result;
    logic [`MULDIV_XLEN-1:0]  product;
    logic [`MULDIV_XLEN-1:0]  mul_a;
    logic [`MULDIV_XLEN-1:0]  mul_b;
    logic                     div_start;
    logic [`MULDIV_XLEN-1:0]  div_a;
    logic [`MULDIV_XLEN-1:0]  div_b;
    logic                     div_ready;
    logic [`MULDIV_XLEN-1:0]  quotient;
    logic [`MULDIV_XLEN-1:0]  remainder;

    // Short-cut results for 0, 1 and -1 operands
    fast_path u_fast_path (.req(req), .fast(fast), .fast_result(fast_result));

    muldiv_ctrl u_ctrl (
        .clk(clk), .reset(reset), .start(start), .req(req),
        .fast(fast), .fast_result(fast_result), .product(product),
        .div_ready(div_ready), .quotient(quotient), .remainder(remainder),
        .mul_a(mul_a), .mul_b(mul_b), .div_start(div_start),
        .div_a(div_a), .div_b(div_b), .done(done), .result(result)
    );

    mul_pipe u_mul (.clk(clk), .reset(reset), .mul_a(mul_a), .mul_b(mul_b), .product(product));

    div_serial u_div (
        .clk(clk), .reset(reset), .div_start(div_start), .div_a(div_a), .div_b(div_b),
        .div_ready(div_ready), .quotient(quotient), .remainder(remainder)
    );

endmodule

// ==== dv/muldiv_properties.sv ====
module muldiv_properties (
    input logic clk,
    input logic reset,
    input logic slow_start,
    input logic is_div,
    input logic div_ready,
    input logic done
);

    // Count of failed properties
    int unsigned fail_count = 0;

    // Divider result leaves one cycle after div_ready
    ready_then_done: assert property (
        @(posedge clk) disable iff (!reset) div_ready |=> done
    ) else begin
        fail_count++;
        $error("done did not follow div_ready in the next cycle");
    end

    // Slow MUL goes through MUL1 and MUL2 before MUL_OUT
    mul_latency: assert property (
        @(posedge clk) disable iff (!reset) (slow_start && !is_div) |-> ##3 done
    ) else begin
        fail_count++;
        $error("slow MUL did not finish three cycles after start");
    end

    // Nothing completes during reset
    quiet_in_reset: assert property (
        @(posedge clk) !reset |-> !done
    ) else begin
        fail_count++;
        $error("done was high while reset was active");
    end

endmodule

// ==== dv/muldiv_tb.sv ====
`include "muldiv_config.svh"

module muldiv_tb
    import muldiv_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int RANDOM_CASES = 200;
    localparam int BUSY_CASES = 3;

    typedef logic [`MULDIV_XLEN-1:0] word_t;

    logic         clk;
    logic         reset;
    logic         start;
    muldiv_req_t  req;
    logic         done;
    word_t        result;

    int           errors = 0;
    int           checks = 0;
    int           seed = 5;
    bit           loaded = 1'b0;

    // Directed cases from the data file
    string        case_name[$];
    muldiv_op_t   case_op[$];
    word_t        case_a[$];
    word_t        case_b[$];
    word_t        case_exp[$];

    muldiv_top DUT (
        .clk(clk), .reset(reset), .start(start), .req(req), .done(done), .result(result)
    );

    bind muldiv_ctrl muldiv_properties u_props (
        .clk(clk), .reset(reset), .slow_start(slow_start), .is_div(is_div),
        .div_ready(div_ready), .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference model applies the fast rules before the RISC-V signed rules
    function automatic word_t model_result(input muldiv_op_t op, input word_t a,
                                           input word_t b, output bit is_fast);
        is_fast = 1'b1;
        if (a == '0) return '0;
        if (b == '0) return (op == OP_DIV) ? '1 : ((op == OP_REM) ? a : '0);
        if (b == word_t'(1)) return (op == OP_REM) ? '0 : a;
        if (b == '1) return (op == OP_REM) ? '0 : -a;
        if (a == word_t'(1)) return (op == OP_MUL) ? b : ((op == OP_DIV) ? '0 : word_t'(1));
        if (a == '1) return (op == OP_MUL) ? -b : ((op == OP_DIV) ? '0 : '1);
        is_fast = 1'b0;
        case (op)
            OP_DIV:  return word_t'($signed(a) / $signed(b));
            OP_REM:  return word_t'($signed(a) % $signed(b));
            default: return a * b;
        endcase
    endfunction

    function automatic muldiv_op_t op_from_text(input logic [8*4-1:0] text);
        if (text == "div") return OP_DIV;
        if (text == "rem") return OP_REM;
        return OP_MUL;
    endfunction

    // Operands of 0, 1 and -1 show up often enough to reach the fast path
    function automatic word_t random_operand();
        int sel;
        sel = $unsigned($random(seed)) % 8;
        case (sel)
            0:       return '0;
            1:       return word_t'(1);
            2:       return '1;
            default: return $random(seed);
        endcase
    endfunction

    function automatic muldiv_op_t random_op();
        int sel;
        sel = $unsigned($random(seed)) % 3;
        if (sel == 1) return OP_DIV;
        if (sel == 2) return OP_REM;
        return OP_MUL;
    endfunction

    task automatic load_cases();
        int fd;
        int n;
        string line;
        logic [8*24-1:0] name_bits;
        logic [8*4-1:0] op_bits;
        word_t a;
        word_t b;
        word_t exp;
        fd = $fopen("dv/muldiv_cases.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Cannot open the case file dv/muldiv_cases.txt");
            return;
        end
        while (!$feof(fd)) begin
            n = $fgets(line, fd);
            // Comment lines skipped here and blank lines fail the scan below
            if (n > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s %s %h %h %h", name_bits, op_bits, a, b, exp);
                if (n == 5) begin
                    case_name.push_back($sformatf("%0s", name_bits));
                    case_op.push_back(op_from_text(op_bits));
                    case_a.push_back(a);
                    case_b.push_back(b);
                    case_exp.push_back(exp);
                end
            end
        end
        $fclose(fd);
        if (case_a.size() == 0) begin
            errors++;
            $display("The case file holds no usable cases");
        end
    endtask

    // Start driven on a falling edge and done sampled at rising edges
    task automatic run_op(input muldiv_op_t op, input word_t a, input word_t b,
                          input bit intrude, output word_t res, output int lat);
        @(negedge clk);
        req.op = op;
        req.a = a;
        req.b = b;
        start = 1'b1;
        lat = 0;
        @(posedge clk);
        while (!done) begin
            @(negedge clk);
            // Second busy cycle gets a stray start with other operands
            if (intrude && lat == 1) begin
                req.op = OP_DIV;
                req.a = 32'h0000_1000;
                req.b = 32'd3;
                start = 1'b1;
            end else begin
                start = 1'b0;
            end
            @(posedge clk);
            lat++;
        end
        res = result;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic check_case(input string name, input muldiv_op_t op, input word_t a,
                              input word_t b, input word_t exp, input bit intrude);
        word_t got;
        int lat;
        int exp_lat;
        bit is_fast;
        void'(model_result(op, a, b, is_fast));
        run_op(op, a, b, intrude, got, lat);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %0s: expected %h, actual %h", name, exp, got);
        end
        // Fast ops finish in the start cycle and slow MUL three cycles later
        exp_lat = is_fast ? 0 : ((op == OP_MUL) ? 3 : -1);
        if (exp_lat >= 0) begin
            assert (lat == exp_lat) else begin
                errors++;
                $display("Fail %0s latency: expected %0d, actual %0d", name, exp_lat, lat);
            end
        end
    endtask

    task automatic random_case(input int index);
        muldiv_op_t op;
        word_t a;
        word_t b;
        word_t exp;
        bit is_fast;
        op = random_op();
        a = random_operand();
        b = random_operand();
        exp = model_result(op, a, b, is_fast);
        check_case($sformatf("random_%0d", index), op, a, b, exp, 1'b0);
    endtask

    // Budget per op covers the longest divide
    initial begin
        wait (loaded);
        #((case_a.size() + BUSY_CASES + RANDOM_CASES + 1) * (`MULDIV_DIV_STEPS + 6) * CLK_PERIOD);
        $display("Timeout: the DUT did not finish all operations in the allowed time");
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int assert_fails;
        reset = 1'b0;
        start = 1'b0;
        req = '0;
        load_cases();
        loaded = 1'b1;
        repeat (3) @(negedge clk);
        reset = 1'b1;
        for (int i = 0; i < case_a.size(); i++) begin
            check_case(case_name[i], case_op[i], case_a[i], case_b[i], case_exp[i], 1'b0);
        end
        // Stray starts while busy
        check_case("busy_mul", OP_MUL, 32'h0001_2345, 32'h0000_0100, 32'h0123_4500, 1'b1);
        check_case("busy_div", OP_DIV, 32'hffff_f000, 32'd7, 32'hffff_fdb7, 1'b1);
        check_case("busy_rem", OP_REM, 32'hffff_f000, 32'd7, 32'hffff_ffff, 1'b1);
        for (int i = 0; i < RANDOM_CASES; i++) begin
            random_case(i);
        end
        assert_fails = DUT.u_ctrl.u_props.fail_count;
        $display("Checks: %0d, check errors: %0d, property failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== dv/muldiv_cases.txt ====
# Columns: name op a b expected
# op is mul, div or rem; a, b and expected are 32-bit hex
mul_a_zero    mul 00000000 12345678 00000000
div_by_zero   div 00000007 00000000 ffffffff
rem_by_zero   rem fffffff9 00000000 fffffff9
mul_b_zero    mul 00000007 00000000 00000000
rem_b_one     rem 87654321 00000001 00000000
div_min_by_m1 div 80000000 ffffffff 80000000
mul_b_m1      mul 00000005 ffffffff fffffffb
rem_a_one     rem 00000001 00000003 00000001
div_a_m1      div ffffffff 00000003 00000000
mul_a_m1      mul ffffffff 00000009 fffffff7
mul_pos       mul 00001234 00005678 06260060
mul_neg       mul fffffffe 00000003 fffffffa
mul_wrap      mul 80000001 00000002 00000002
div_pos_pos   div 00000064 00000007 0000000e
rem_pos_pos   rem 00000064 00000007 00000002
div_neg_pos   div ffffff9c 00000007 fffffff2
rem_neg_pos   rem ffffff9c 00000007 fffffffe
div_pos_neg   div 00000064 fffffff9 fffffff2
rem_pos_neg   rem 00000064 fffffff9 00000002
div_neg_neg   div ffffff9c fffffff9 0000000e
rem_neg_neg   rem ffffff9c fffffff9 fffffffe

// ==== sources.f ====
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/operand_pkg.sv
hdl/fast_path.sv
hdl/mul_pipe.sv
hdl/div_serial.sv
hdl/muldiv_ctrl.sv
hdl/muldiv_top.sv
dv/muldiv_properties.sv
dv/muldiv_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= muldiv_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+100
FAIL_MSG  ?= Simulation FAILED
PASS_MSG  ?= Simulation PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "No pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
